//--- rtl/i2c_master_pkg.sv
// Shared types and constants for the I2C master bus sequencer
// RTL files refer to these by scoped name, without import

package i2c_master_pkg;

    // ==============================
    // Widths
    // ==============================

    localparam int BITS_PER_BYTE = 8;

    typedef logic [BITS_PER_BYTE-1:0] byte_t;   // One bus byte, MSB first on the wire
    typedef logic [2:0] bit_idx_t;              // Bit position inside a byte
    typedef logic [2:0] tx_req_cnt_t;           // Bytes to write after the address
    typedef logic [3:0] tx_cnt_t;               // Written bytes, address included

    // ==============================
    // Bus phases
    // ==============================

    // Each bit slot is three phases: SCL low, SCL high, SCL low
    typedef enum logic [4:0] {
        ph_idle,
        ph_start,       // SDA falls while SCL high
        ph_scl_low,     // First SCL low of a write run
        ph_wr0,
        ph_wr1,
        ph_wr2,
        ph_ack_rx0,     // Line released for the slave ACK
        ph_ack_rx1,
        ph_ack_rx2,
        ph_rep0,        // Repeated START sequence
        ph_rep1,
        ph_rep2,
        ph_rd0,
        ph_rd1,
        ph_rd2,
        ph_ack_tx0,     // Master ACK or NACK
        ph_ack_tx1,
        ph_ack_tx2,
        ph_both_low,    // STOP sequence
        ph_scl_high,
        ph_stop
    } phase_e;

endpackage

//--- rtl/i2c_phase_fsm.sv
// Bus phase state machine of the I2C master
// Steps one phase per enabled cycle and decodes the SCL level, the SDA
// control level and direction, and the strobes used by the counters and
// shifters. Write bits take SDA from the transmit shifter via data_sel

module i2c_phase_fsm (
    input  logic CLK,
    input  logic RST_N,
    input  logic clk_en,
    input  logic start,
    input  logic rw,
    input  logic rep_pending,
    input  logic last_bit,
    input  logic last_tx_byte,
    input  logic last_rx_byte,
    output logic busy,
    output logic scl,
    output logic sda_ctl,
    output logic sda_oe,
    output logic data_sel,
    output logic write_phase,
    output logic read_phase,
    output logic bit_end,
    output logic ack_end,
    output logic rep_restart,
    output logic start_strobe,
    output logic scl_high
);

    i2c_master_pkg::phase_e phase;
    i2c_master_pkg::phase_e phase_nxt;
    logic                   rw_q;       // Read request of the running transaction

    // ==============================
    // Phase sequence
    // ==============================

    always_comb begin
        phase_nxt = phase;
        case (phase)
            i2c_master_pkg::ph_idle: begin
                if (start) begin
                    phase_nxt = i2c_master_pkg::ph_start;
                end
            end
            i2c_master_pkg::ph_start:    phase_nxt = i2c_master_pkg::ph_scl_low;
            i2c_master_pkg::ph_scl_low:  phase_nxt = i2c_master_pkg::ph_wr0;
            i2c_master_pkg::ph_wr0:      phase_nxt = i2c_master_pkg::ph_wr1;
            i2c_master_pkg::ph_wr1:      phase_nxt = i2c_master_pkg::ph_wr2;
            i2c_master_pkg::ph_wr2: begin
                phase_nxt = last_bit ? i2c_master_pkg::ph_ack_rx0 : i2c_master_pkg::ph_wr0;
            end
            i2c_master_pkg::ph_ack_rx0:  phase_nxt = i2c_master_pkg::ph_ack_rx1;
            i2c_master_pkg::ph_ack_rx1:  phase_nxt = i2c_master_pkg::ph_ack_rx2;
            i2c_master_pkg::ph_ack_rx2: begin
                if (!last_tx_byte) begin
                    phase_nxt = i2c_master_pkg::ph_wr0;         // More bytes in this run
                end else if (rep_pending) begin
                    phase_nxt = i2c_master_pkg::ph_rep0;
                end else if (rw_q) begin
                    phase_nxt = i2c_master_pkg::ph_rd0;
                end else begin
                    phase_nxt = i2c_master_pkg::ph_both_low;
                end
            end
            i2c_master_pkg::ph_rep0:     phase_nxt = i2c_master_pkg::ph_rep1;
            i2c_master_pkg::ph_rep1:     phase_nxt = i2c_master_pkg::ph_rep2;
            i2c_master_pkg::ph_rep2:     phase_nxt = i2c_master_pkg::ph_scl_low;
            i2c_master_pkg::ph_rd0:      phase_nxt = i2c_master_pkg::ph_rd1;
            i2c_master_pkg::ph_rd1:      phase_nxt = i2c_master_pkg::ph_rd2;
            i2c_master_pkg::ph_rd2: begin
                phase_nxt = last_bit ? i2c_master_pkg::ph_ack_tx0 : i2c_master_pkg::ph_rd0;
            end
            i2c_master_pkg::ph_ack_tx0:  phase_nxt = i2c_master_pkg::ph_ack_tx1;
            i2c_master_pkg::ph_ack_tx1:  phase_nxt = i2c_master_pkg::ph_ack_tx2;
            i2c_master_pkg::ph_ack_tx2: begin
                phase_nxt = last_rx_byte ? i2c_master_pkg::ph_both_low : i2c_master_pkg::ph_rd0;
            end
            i2c_master_pkg::ph_both_low: phase_nxt = i2c_master_pkg::ph_scl_high;
            i2c_master_pkg::ph_scl_high: phase_nxt = i2c_master_pkg::ph_stop;
            default:                     phase_nxt = i2c_master_pkg::ph_idle;
        endcase
    end

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            phase <= i2c_master_pkg::ph_idle;
            rw_q  <= 1'b0;
        end else if (clk_en) begin
            phase <= phase_nxt;
            if (phase == i2c_master_pkg::ph_idle && start) begin
                rw_q <= rw;
            end
        end
    end

    // ==============================
    // Line levels and strobes
    // ==============================

    always_comb begin
        busy         = 1'b1;
        scl          = 1'b0;
        sda_ctl      = 1'b1;
        sda_oe       = 1'b1;
        data_sel     = 1'b0;
        write_phase  = 1'b0;
        read_phase   = 1'b0;
        bit_end      = 1'b0;
        ack_end      = 1'b0;
        rep_restart  = 1'b0;
        start_strobe = 1'b0;
        scl_high     = 1'b0;
        case (phase)
            i2c_master_pkg::ph_idle: begin
                busy   = 1'b0;
                scl    = 1'b1;
                sda_oe = 1'b0;      // Bus released
            end
            i2c_master_pkg::ph_start: begin
                scl     = 1'b1;
                sda_ctl = 1'b0;
            end
            i2c_master_pkg::ph_scl_low: begin
                sda_ctl      = 1'b0;
                start_strobe = 1'b1;  // First byte of a run loads here
            end
            i2c_master_pkg::ph_wr0,
            i2c_master_pkg::ph_wr1,
            i2c_master_pkg::ph_wr2: begin
                data_sel    = 1'b1;
                write_phase = 1'b1;
                bit_end     = (phase == i2c_master_pkg::ph_wr2);
            end
            i2c_master_pkg::ph_ack_rx0,
            i2c_master_pkg::ph_ack_rx1,
            i2c_master_pkg::ph_ack_rx2: begin
                sda_oe  = 1'b0;     // Slave ACK, not checked
                ack_end = (phase == i2c_master_pkg::ph_ack_rx2);
            end
            i2c_master_pkg::ph_rep0: begin
                rep_restart = 1'b1;
            end
            i2c_master_pkg::ph_rep2: begin
                scl     = 1'b1;
                sda_ctl = 1'b0;     // Repeated START edge
            end
            i2c_master_pkg::ph_rd0,
            i2c_master_pkg::ph_rd1,
            i2c_master_pkg::ph_rd2: begin
                sda_oe     = 1'b0;
                read_phase = 1'b1;
                bit_end    = (phase == i2c_master_pkg::ph_rd2);
            end
            i2c_master_pkg::ph_ack_tx0,
            i2c_master_pkg::ph_ack_tx1,
            i2c_master_pkg::ph_ack_tx2: begin
                sda_ctl = last_rx_byte;   // NACK only on the last read byte
                ack_end = (phase == i2c_master_pkg::ph_ack_tx2);
            end
            i2c_master_pkg::ph_both_low: begin
                sda_ctl = 1'b0;
            end
            i2c_master_pkg::ph_scl_high: begin
                scl     = 1'b1;
                sda_ctl = 1'b0;
            end
            i2c_master_pkg::ph_stop: begin
                scl = 1'b1;
            end
            default: begin
            end
        endcase

        // Middle phase of every bit slot has SCL high
        if (phase inside {i2c_master_pkg::ph_wr1, i2c_master_pkg::ph_ack_rx1,
                          i2c_master_pkg::ph_rep1, i2c_master_pkg::ph_rd1,
                          i2c_master_pkg::ph_ack_tx1}) begin
            scl      = 1'b1;
            scl_high = 1'b1;
        end
    end

    // A read byte never starts once the read count is used up
    a_rd_not_done: assert property (@(posedge CLK) disable iff (!RST_N)
        phase == i2c_master_pkg::ph_rd0 |-> !last_rx_byte);

endmodule

//--- rtl/i2c_xfer_counters.sv
// Bit, write-byte and read-byte counters of the I2C master
// Byte counts are captured at an accepted start. The repeated-start
// request is held until the restart, and load_next asks for the next
// write byte when one more follows in the same run

module i2c_xfer_counters #(
    parameter int RX_CNT_W = 5
) (
    input  logic                        CLK,
    input  logic                        RST_N,
    input  logic                        clk_en,
    input  logic                        start,        // Accepted start only
    input  logic                        rep_start,
    input  i2c_master_pkg::tx_req_cnt_t num_tx_bytes,
    input  logic [RX_CNT_W-1:0]         num_rx_bytes,
    input  logic                        bit_end,
    input  logic                        ack_end,
    input  logic                        write_phase,
    input  logic                        read_phase,
    input  logic                        rep_restart,
    output logic                        last_bit,
    output logic                        last_tx_byte,
    output logic                        last_rx_byte,
    output logic                        rep_pending,
    output logic                        load_next
);

    localparam i2c_master_pkg::bit_idx_t LAST_IDX =
        i2c_master_pkg::bit_idx_t'(i2c_master_pkg::BITS_PER_BYTE - 1);

    i2c_master_pkg::bit_idx_t    bit_cnt;
    i2c_master_pkg::tx_cnt_t     tx_cnt;
    i2c_master_pkg::tx_cnt_t     tx_total;    // Address plus requested bytes
    i2c_master_pkg::tx_req_cnt_t num_tx_q;
    logic [RX_CNT_W-1:0]         rx_cnt;
    logic [RX_CNT_W-1:0]         num_rx_q;
    logic                        byte_end;

    assign last_bit     = (bit_cnt == LAST_IDX);
    assign byte_end     = bit_end && last_bit;
    assign tx_total     = i2c_master_pkg::tx_cnt_t'(num_tx_q) + i2c_master_pkg::tx_cnt_t'(1);
    assign last_tx_byte = (tx_cnt == tx_total);
    assign last_rx_byte = (rx_cnt == num_rx_q);
    // Count is still the old one here, so compare against num_tx_q
    assign load_next = write_phase && byte_end &&
                       (tx_cnt != i2c_master_pkg::tx_cnt_t'(num_tx_q));

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            bit_cnt     <= '0;
            tx_cnt      <= '0;
            rx_cnt      <= '0;
            num_tx_q    <= '0;
            num_rx_q    <= '0;
            rep_pending <= 1'b0;
        end else if (clk_en) begin
            if (start) begin
                bit_cnt     <= '0;
                tx_cnt      <= '0;
                rx_cnt      <= '0;
                num_tx_q    <= num_tx_bytes;
                num_rx_q    <= num_rx_bytes;
                rep_pending <= rep_start;
            end else begin
                if (bit_end) begin
                    bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
                end

                if (rep_restart) begin
                    tx_cnt      <= i2c_master_pkg::tx_cnt_t'(1);  // Repeated address is byte one
                    rep_pending <= 1'b0;
                end else if (ack_end && last_tx_byte) begin
                    tx_cnt <= '0;
                end else if (write_phase && byte_end) begin
                    tx_cnt <= tx_cnt + 1'b1;
                end

                if (ack_end && last_rx_byte) begin
                    rx_cnt <= '0;
                end else if (read_phase && byte_end) begin
                    rx_cnt <= rx_cnt + 1'b1;
                end
            end
        end
    end

    a_rx_cnt_bound: assert property (@(posedge CLK) disable iff (!RST_N)
        rx_cnt <= num_rx_q);

endmodule

//--- rtl/i2c_tx_shifter.sv
// Transmit shift register of the I2C master
// Loads a byte on load and presents it MSB first on data_bit,
// moving one bit left at the end of every write bit but the last

module i2c_tx_shifter (
    input  logic                  CLK,
    input  logic                  RST_N,
    input  logic                  clk_en,
    input  logic                  load,
    input  logic                  shift,
    input  i2c_master_pkg::byte_t tx_data,
    output logic                  data_bit
);

    localparam int MSB = i2c_master_pkg::BITS_PER_BYTE - 1;

    i2c_master_pkg::byte_t sreg;

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            sreg <= '1;                             // Idle level of the line
        end else if (clk_en) begin
            if (load) begin
                sreg <= tx_data;
            end else if (shift) begin
                sreg <= {sreg[MSB-1:0], 1'b1};      // Next bit to the MSB
            end
        end
    end

    assign data_bit = sreg[MSB];

    // Load follows the last bit only, shifts never do
    a_load_shift_excl: assert property (@(posedge CLK) disable iff (!RST_N)
        !(load && shift));

endmodule

//--- rtl/i2c_rx_shifter.sv
// Receive shift register of the I2C master
// Samples sda_in MSB first while SCL is high in read bits. At the end of
// the last bit the byte moves to rx_data, and rx_valid pulses for one
// clock in the following enabled cycle

module i2c_rx_shifter (
    input  logic                  CLK,
    input  logic                  RST_N,
    input  logic                  clk_en,
    input  logic                  sample,
    input  logic                  byte_done,
    input  logic                  sda_in,
    output i2c_master_pkg::byte_t rx_data,
    output logic                  rx_valid
);

    localparam int MSB = i2c_master_pkg::BITS_PER_BYTE - 1;

    i2c_master_pkg::byte_t sreg;
    logic                  valid_q;     // Set for one enabled period after a byte

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            valid_q <= 1'b0;
        end else if (clk_en) begin
            valid_q <= byte_done;
        end
    end

    // Data path
    always_ff @(posedge CLK) begin
        if (clk_en) begin
            if (sample) begin
                sreg <= {sreg[MSB-1:0], sda_in};
            end
            if (byte_done) begin
                rx_data <= sreg;    // All eight samples are in by now
            end
        end
    end

    assign rx_valid = valid_q && clk_en;

endmodule

//--- rtl/i2c_master.sv
// Top level of the I2C master bus sequencer
// One start pulse runs a full transaction: START, write bytes, an optional
// repeated START with more write bytes, optional reads, then STOP.
// Write data is pulled through tx_data/tx_req, read data comes out on
// rx_data/rx_valid. Each bit takes three cycles with clk_en high

module i2c_master #(
    parameter int RX_CNT_W = 5
) (
    input  logic                        CLK,
    input  logic                        RST_N,
    input  logic                        clk_en,
    input  logic                        start,
    input  logic                        rep_start,
    input  logic                        rw,
    input  i2c_master_pkg::tx_req_cnt_t num_tx_bytes,
    input  logic [RX_CNT_W-1:0]         num_rx_bytes,
    input  i2c_master_pkg::byte_t       tx_data,
    input  logic                        sda_in,
    output logic                        busy,
    output logic                        tx_req,
    output logic                        rx_valid,
    output i2c_master_pkg::byte_t       rx_data,
    output logic                        scl,
    output logic                        sda_out,
    output logic                        sda_oe
);

    // FSM strobes
    logic sda_ctl, data_sel, write_phase, read_phase;
    logic bit_end, ack_end, rep_restart, start_strobe, scl_high;
    // Counter flags
    logic last_bit, last_tx_byte, last_rx_byte, rep_pending, load_next;
    // Shifter controls
    logic start_acc, load, shift, tx_bit;

    assign start_acc = start && !busy;                  // Ignored during a transaction
    assign load      = start_strobe || load_next;
    assign shift     = write_phase && bit_end && !last_bit;
    assign tx_req    = load && clk_en;                  // One clock per taken byte
    assign sda_out   = data_sel ? tx_bit : sda_ctl;

    i2c_phase_fsm u_phase_fsm (
        .CLK, .RST_N, .clk_en,
        .start, .rw, .rep_pending,
        .last_bit, .last_tx_byte, .last_rx_byte,
        .busy, .scl, .sda_ctl, .sda_oe, .data_sel,
        .write_phase, .read_phase, .bit_end, .ack_end,
        .rep_restart, .start_strobe, .scl_high
    );

    i2c_xfer_counters #(
        .RX_CNT_W(RX_CNT_W)
    ) u_counters (
        .CLK, .RST_N, .clk_en,
        .start        (start_acc),
        .rep_start, .num_tx_bytes, .num_rx_bytes,
        .bit_end, .ack_end, .write_phase, .read_phase, .rep_restart,
        .last_bit, .last_tx_byte, .last_rx_byte, .rep_pending, .load_next
    );

    i2c_tx_shifter u_tx_shifter (
        .CLK, .RST_N, .clk_en,
        .load, .shift, .tx_data,
        .data_bit     (tx_bit)
    );

    i2c_rx_shifter u_rx_shifter (
        .CLK, .RST_N, .clk_en,
        .sample       (read_phase && scl_high),
        .byte_done    (read_phase && bit_end && last_bit),
        .sda_in,
        .rx_data, .rx_valid
    );

endmodule

//--- include/tb_i2c_cases.svh
// Transaction table for the I2C master testbench
// Included inside the testbench module, one row per bus transaction.
// Write bytes run address first. With rep_start the repeated address
// follows the first run's bytes directly

typedef struct packed {
    logic                              rw;
    logic                              rep_start;
    i2c_master_pkg::tx_req_cnt_t       num_tx;
    logic [4:0]                        num_rx;
    logic                              seeded;    // Read data from the LFSR
    i2c_master_pkg::byte_t [0:7]       tx;        // Bytes expected on tx_data
    i2c_master_pkg::byte_t [0:3]       rd;        // Slave read data
} case_t;

localparam int NUM_CASES = 7;

// ==============================
// Columns: rw, rep_start, num_tx, num_rx, seeded, write bytes, read bytes
// ==============================
localparam case_t CASES [NUM_CASES] = '{
    // Plain write, address plus two bytes
    '{1'b0, 1'b0, 3'd2, 5'd0, 1'b0, 64'hA0_11_22_00_00_00_00_00, 32'h00_00_00_00},
    // Address only
    '{1'b0, 1'b0, 3'd0, 5'd0, 1'b0, 64'hA2_00_00_00_00_00_00_00, 32'h00_00_00_00},
    // Read of three bytes straight after the address
    '{1'b1, 1'b0, 3'd0, 5'd3, 1'b0, 64'hA1_00_00_00_00_00_00_00, 32'h5A_C3_0F_00},
    // Register write, repeated START, then two reads
    '{1'b1, 1'b1, 3'd2, 5'd2, 1'b0, 64'hA0_33_44_A1_55_00_00_00, 32'h96_E7_00_00},
    // Repeated START read with LFSR data
    '{1'b1, 1'b1, 3'd1, 5'd4, 1'b1, 64'hA0_77_A1_00_00_00_00_00, 32'h00_00_00_00},
    // Write, repeated START, write
    '{1'b0, 1'b1, 3'd1, 5'd0, 1'b0, 64'hA4_12_A4_00_00_00_00_00, 32'h00_00_00_00},
    // Single read byte, NACK right away
    '{1'b1, 1'b0, 3'd1, 5'd1, 1'b0, 64'hA6_08_00_00_00_00_00_00, 32'h3C_00_00_00}
};

//--- verification/tb_i2c_master.sv
// Testbench for the I2C master bus sequencer
// Runs the transaction table against a bus slave model that decodes
// START, STOP and bytes on SCL/SDA, ACKs writes and serves read data.
// Results are checked per transaction after busy falls

module tb_i2c_master;
    timeunit 1ns;
    timeprecision 1ps;

    `include "tb_i2c_cases.svh"

    localparam int RX_CNT_W = 5;
    localparam int TIMEOUT  = 2000;     // Cycles per wait

    logic CLK, RST_N, clk_en, start, rep_start, rw, sda_in;
    logic busy, tx_req, rx_valid, scl, sda_out, sda_oe;
    i2c_master_pkg::tx_req_cnt_t num_tx_bytes;
    logic [RX_CNT_W-1:0]         num_rx_bytes;
    i2c_master_pkg::byte_t       tx_data, rx_data;

    int n_err = 0;
    int n_chk = 0;
    int case_idx, tx_pos, tx_req_cnt, bit_pos, rd_idx, rep_cnt, rep_at, stop_cnt, wr_total;
    case_t cur;
    logic [31:0] lfsr = 32'hf4c6837d;
    logic slave_sda = 1'b1;             // Slave drive, 1 is released
    logic scl_q, sda_q, in_txn, in_read, rd_done;
    i2c_master_pkg::byte_t sh;
    i2c_master_pkg::byte_t slave_rd [0:3];
    i2c_master_pkg::byte_t wr_seen [$];
    i2c_master_pkg::byte_t rx_seen [$];
    logic acks [$];

    assign sda_in = sda_oe ? sda_out : slave_sda;   // Open-drain line with pull-up

    i2c_master #(.RX_CNT_W(RX_CNT_W)) u_i2c_master (
        .CLK, .RST_N, .clk_en, .start, .rep_start, .rw, .num_tx_bytes, .num_rx_bytes,
        .tx_data, .sda_in, .busy, .tx_req, .rx_valid, .rx_data, .scl, .sda_out, .sda_oe
    );

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    always @(posedge CLK) begin
        #1;
        clk_en <= !clk_en;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic frame_reads();
        return in_txn && cur.rw && !rd_done && wr_seen.size() >= wr_total;
    endfunction

    // ==============================
    // Bus slave model
    // ==============================
    always @(negedge CLK) begin
        if (!RST_N) begin
            scl_q = 1'b1;
            sda_q = 1'b1;
            in_txn = 1'b0;
            in_read = 1'b0;
            bit_pos = 0;
            slave_sda = 1'b1;
        end else begin
            if (scl && scl_q && sda_q && !sda_in) begin         // START or repeated START
                if (in_txn) begin
                    rep_cnt++;
                    rep_at = wr_seen.size();
                end
                in_txn = 1'b1;
                bit_pos = 0;
                in_read = frame_reads();
            end else if (scl && scl_q && !sda_q && sda_in) begin
                stop_cnt++;
                in_txn = 1'b0;
                in_read = 1'b0;
                bit_pos = 0;
                slave_sda = 1'b1;
            end else if (scl && !scl_q) begin
                if (bit_pos < 8) begin
                    sh = {sh[6:0], sda_in};
                    bit_pos++;
                    if (bit_pos == 8 && !in_read) wr_seen.push_back(sh);
                end else begin
                    if (in_read) begin                          // Master ACK bit
                        acks.push_back(sda_in);
                        rd_idx++;
                        rd_done = sda_in;
                    end
                    bit_pos = 0;
                    in_read = frame_reads();
                end
            end else if (!scl && scl_q) begin
                if (bit_pos == 8) slave_sda = in_read;          // ACK writes only
                else if (in_read && rd_idx < 4) slave_sda = slave_rd[rd_idx][7 - bit_pos];
                else slave_sda = 1'b1;
            end
            scl_q = scl;
            sda_q = sda_in;
        end
    end

    always @(negedge CLK) begin
        if (RST_N && rx_valid) rx_seen.push_back(rx_data);
    end

    // Write data source, next byte after each taken one
    always begin
        @(negedge CLK);
        if (tx_req === 1'b1) begin
            tx_req_cnt++;
            @(posedge CLK);
            #1;
            tx_pos++;
            if (tx_pos < 8) tx_data = cur.tx[tx_pos];
        end
    end

    // ==============================
    // Checks and flow
    // ==============================
    task automatic check_byte(input string name, input i2c_master_pkg::byte_t got, exp);
        n_chk++;
        if (got !== exp) begin
            n_err++;
            $display("error: case %0d %s got %h expected %h", case_idx, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        n_chk++;
        if (got !== exp) begin
            n_err++;
            $display("error: case %0d %s got %h expected %h", case_idx, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, exp);
        n_chk++;
        if (got != exp) begin
            n_err++;
            $display("error: case %0d %s got %0h expected %0h", case_idx, name, got, exp);
        end
    endtask

    task automatic end_run();
        $display("checks: %0d, errors: %0d", n_chk, n_err);
        if (n_err == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        while (busy !== level && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        if (busy !== level) begin
            n_err++;
            $display("timeout: case %0d busy never went to %0d", case_idx, level);
            end_run();
        end
    endtask

    // Returns at a rising edge with clk_en low, so the next edge is enabled
    task automatic wait_enable_slot();
        int n;
        n = 0;
        @(posedge CLK);
        while (clk_en !== 1'b0 && n < 4) begin
            @(posedge CLK);
            n++;
        end
        if (clk_en !== 1'b0) begin
            n_err++;
            $display("timeout: clk_en did not toggle");
            end_run();
        end
    endtask

    task automatic drive_case_inputs(input logic go, input case_t c);
        start = go;
        rw = c.rw;
        rep_start = c.rep_start;
        num_tx_bytes = c.num_tx;
        num_rx_bytes = c.num_rx;
    endtask

    task automatic run_case(input int idx);
        int n_wr;
        int n_rd;
        case_t poke;
        i2c_master_pkg::byte_t b;
        case_idx = idx;
        cur = CASES[idx];
        n_wr = int'(cur.num_tx) + 1 + (cur.rep_start ? int'(cur.num_tx) : 0);
        n_rd = cur.rw ? int'(cur.num_rx) : 0;
        for (int k = 0; k < 4; k++) begin
            if (cur.seeded) begin
                for (int j = 0; j < 8; j++) begin
                    lfsr = lfsr_next(lfsr);
                    b = {b[6:0], lfsr[0]};
                end
                slave_rd[k] = b;
            end else begin
                slave_rd[k] = cur.rd[k];
            end
        end
        wr_seen.delete();
        rx_seen.delete();
        acks.delete();
        {rd_idx, rep_cnt, rep_at, stop_cnt, tx_req_cnt, tx_pos} = '0;
        rd_done = 1'b0;
        wr_total = n_wr;
        tx_data = cur.tx[0];

        wait_enable_slot();
        #1;
        drive_case_inputs(1'b1, cur);
        @(posedge CLK);
        #1;
        start = 1'b0;
        wait_busy(1'b1);

        // Start pulse with other settings while busy, must be ignored
        poke = cur;
        poke.rw = !cur.rw;
        poke.rep_start = 1'b1;
        poke.num_tx = 3'd7;
        repeat (20) @(posedge CLK);
        #1;
        drive_case_inputs(1'b1, poke);
        repeat (2) @(posedge CLK);
        #1;
        drive_case_inputs(1'b0, cur);
        wait_busy(1'b0);

        check_count("written bytes", wr_seen.size(), n_wr);
        for (int k = 0; k < n_wr && k < wr_seen.size(); k++) check_byte("bus byte", wr_seen[k], cur.tx[k]);
        check_count("tx_req pulses", tx_req_cnt, n_wr);
        check_count("stop conditions", stop_cnt, 1);
        check_count("repeated starts", rep_cnt, int'(cur.rep_start));
        if (cur.rep_start) check_count("bytes before repeated start", rep_at, int'(cur.num_tx) + 1);
        check_count("rx_valid pulses", rx_seen.size(), n_rd);
        for (int k = 0; k < n_rd && k < rx_seen.size(); k++) check_byte("rx_data", rx_seen[k], slave_rd[k]);
        check_count("master ack bits", acks.size(), n_rd);
        for (int k = 0; k < n_rd && k < acks.size(); k++) check_bit("master ack", acks[k], k == n_rd - 1);
    endtask

    initial begin
        clk_en = 1'b0;
        RST_N = 1'b0;
        tx_data = '0;
        drive_case_inputs(1'b0, CASES[0]);
        case_idx = -1;
        repeat (16) @(posedge CLK);
        #1;
        RST_N = 1'b1;
        @(negedge CLK);
        check_bit("busy", busy, 1'b0);
        check_bit("tx_req", tx_req, 1'b0);
        check_bit("rx_valid", rx_valid, 1'b0);
        check_bit("scl", scl, 1'b1);
        check_bit("sda_out", sda_out, 1'b1);
        check_bit("sda_oe", sda_oe, 1'b0);
        for (int i = 0; i < NUM_CASES; i++) run_case(i);
        end_run();
    end

endmodule

//--- all.f
+incdir+include
rtl/i2c_master_pkg.sv
rtl/i2c_phase_fsm.sv
rtl/i2c_xfer_counters.sv
rtl/i2c_tx_shifter.sv
rtl/i2c_rx_shifter.sv
rtl/i2c_master.sv
verification/tb_i2c_master.sv
